// File: source/neoIoPkg.sv
package neoIoPkg;

	// Response FIFO size, also the credits the requester starts with
	localparam int RespDepth = 4;
	localparam int RespPtrW = $clog2(RespDepth);

	// Byte seen on reads nobody answers
	localparam logic [7:0] ZoneUnmapped = 8'hFF;

	// Limits of the I/O register zone
	localparam logic [23:0] ZoneBase = 24'h300000;
	localparam logic [23:0] ZoneLast = 24'h3BFFFF;

	// Main decode mask and the matches after masking
	localparam logic [23:0] ZoneMask = 24'h3E0001;
	localparam logic [23:0] AddrP1Cnt = 24'h300000;
	localparam logic [23:0] AddrDipRd = 24'h300001;
	localparam logic [23:0] AddrStatusA = 24'h320001;
	localparam logic [23:0] AddrP2Cnt = 24'h340000;
	localparam logic [23:0] AddrStatusB = 24'h380000;
	// Bit write zone 0, sub-decoded on A6:A4
	localparam logic [23:0] AddrBitW0 = 24'h380001;
	// Bit write zone 1, the system latch
	localparam logic [23:0] AddrBitW1 = 24'h3A0001;

	typedef enum logic {
		accRead,
		accWrite
	} accessKindT;

	typedef enum logic [3:0] {
		regNone,
		// Read side
		regP1Cnt,
		regDipSw,
		regStatusA,
		regP2Cnt,
		regStatusB,
		// Write side
		regPOutput,
		regCrdBank,
		regSlot,
		regLedLatch,
		regLedData,
		regCounter,
		regSysLatch
	} regSelT;

	// One CPU byte access
	typedef struct packed {
		accessKindT kind;
		logic [23:0] addr;
		logic [7:0] data;
	} ioReqT;

	// Decoded access, stage 1 to stage 2
	typedef struct packed {
		regSelT sel;
		accessKindT kind;
		logic [7:0] addrLow;
		logic [7:0] data;
	} ioOpT;

	typedef struct packed {
		logic [7:0] data;
		logic wasWrite;
	} ioRespT;

	// Board output latches
	typedef struct packed {
		logic [2:0] p1Out;
		logic [2:0] p2Out;
		logic [2:0] crdBank;
		logic [2:0] slot;
		logic [7:0] led1;
		logic [7:0] led2;
		logic counter1;
		logic counter2;
		logic lockout1;
		logic lockout2;
		// Bit 0 shadow, 1 vector swap, 2 card WE, 3 card WE B,
		// 4 register enable, 5 system rom, 6 sram lock, 7 palette bank
		logic [7:0] sysLatch;
	} ioLatchT;

endpackage

// File: source/neoIoDecode.sv
module neoIoDecode
	import neoIoPkg::*;
(
	input logic clk24M,
	input logic rstN,
	input logic reqValid,
	input ioReqT req,
	output logic opValid,
	output ioOpT op
);

	logic [23:0] zoneAddr;
	regSelT addrSel;
	regSelT opSel;
	logic selIsWrite;
	logic reqIsWrite;

	// Keep only the bits the board decoder looks at
	assign zoneAddr = req.addr & ZoneMask;

	// Address only classification, direction checked below
	always_comb begin
		addrSel = regNone;
		case (zoneAddr)
			AddrP1Cnt: addrSel = regP1Cnt;
			AddrDipRd: begin
				// A7 set is the mirror port, not modelled
				if (!req.addr[7]) begin
					addrSel = regDipSw;
				end
			end
			AddrStatusA: addrSel = regStatusA;
			AddrP2Cnt: addrSel = regP2Cnt;
			AddrStatusB: addrSel = regStatusB;
			AddrBitW0: begin
				// Sub-decode on A6:A4
				case (req.addr[6:4])
					3'b000: addrSel = regPOutput;
					3'b001: addrSel = regCrdBank;
					3'b010: addrSel = regSlot;
					3'b011: addrSel = regLedLatch;
					3'b100: addrSel = regLedData;
					// RTC control, writes dropped
					3'b101: addrSel = regNone;
					default: addrSel = regCounter;
				endcase
			end
			AddrBitW1: addrSel = regSysLatch;
			default: addrSel = regNone;
		endcase
	end

	// Write-only selects sit at the top of the enum
	assign selIsWrite = (addrSel >= regPOutput);
	assign reqIsWrite = (req.kind == accWrite);

	// Wrong direction falls through to the unmapped path
	assign opSel = (selIsWrite == reqIsWrite) ? addrSel : regNone;

	// Valid flag, cleared by reset
	always_ff @(posedge clk24M) begin
		if (!rstN) begin
			opValid <= 1'b0;
		end else begin
			opValid <= reqValid;
		end
	end

	// Op payload, qualified by opValid
	always_ff @(posedge clk24M) begin
		op.sel <= opSel;
		op.kind <= req.kind;
		op.addrLow <= req.addr[7:0];
		op.data <= req.data;
	end

	// Requester must stay inside the I/O zone
	zoneCheck: assert property (@(posedge clk24M) disable iff (!rstN)
		reqValid |-> (req.addr >= ZoneBase && req.addr <= ZoneLast));

endmodule

// File: source/neoIoRegs.sv
module neoIoRegs
	import neoIoPkg::*;
(
	input logic clk24M,
	input logic rstN,
	input logic opValid,
	input ioOpT op,
	input logic [9:0] p1In,
	input logic [9:0] p2In,
	input logic testBtn,
	input logic [7:0] dipSw,
	output logic pushValid,
	output ioRespT pushResp,
	output ioLatchT latches
);

	// Byte staged by LedData, shown on LedLatch
	logic [7:0] ledData;
	logic [7:0] readByte;
	logic writeOp;
	logic bitValue;

	assign writeOp = opValid && (op.kind == accWrite);

	// Counters and system latch take their value from A4
	assign bitValue = op.addrLow[4];

	// Write latches
	always_ff @(posedge clk24M) begin
		if (!rstN) begin
			latches <= '0;
			ledData <= '0;
		end else if (writeOp) begin
			case (op.sel)
				regPOutput: begin
					latches.p1Out <= op.data[2:0];
					latches.p2Out <= op.data[5:3];
				end
				regCrdBank: latches.crdBank <= op.data[2:0];
				regSlot: latches.slot <= op.data[2:0];
				regLedData: ledData <= op.data;
				regLedLatch: begin
					// Bit 3 strobes LED bank 1, bit 4 bank 2
					if (op.data[3]) begin
						latches.led1 <= ledData;
					end
					if (op.data[4]) begin
						latches.led2 <= ledData;
					end
				end
				regCounter: begin
					// A2:A1 picks the output
					case (op.addrLow[2:1])
						2'd0: latches.counter1 <= bitValue;
						2'd1: latches.counter2 <= bitValue;
						2'd2: latches.lockout1 <= bitValue;
						default: latches.lockout2 <= bitValue;
					endcase
				end
				// One bit per address, A3:A1 is the index
				regSysLatch: latches.sysLatch[op.addrLow[3:1]] <= bitValue;
				default: begin
					// regNone and read selects, nothing to store
				end
			endcase
		end
	end

	// Read mux from live inputs
	always_comb begin
		case (op.sel)
			regP1Cnt: readByte = p1In[7:0];
			regP2Cnt: readByte = p2In[7:0];
			regDipSw: readByte = dipSw;
			// Upper bits float high on the board
			regStatusA: readByte = {7'b1111100, testBtn};
			// Start and select lines of both players
			regStatusB: readByte = {4'hF, p2In[9:8], p1In[9:8]};
			default: readByte = ZoneUnmapped;
		endcase
	end

	// Push strobe
	always_ff @(posedge clk24M) begin
		if (!rstN) begin
			pushValid <= 1'b0;
		end else begin
			pushValid <= opValid;
		end
	end

	// Response byte, writes answer zero
	always_ff @(posedge clk24M) begin
		pushResp.wasWrite <= (op.kind == accWrite);
		pushResp.data <= (op.kind == accWrite) ? 8'h00 : readByte;
	end

	// A dropped write must not disturb any output
	noneWriteHold: assert property (@(posedge clk24M) disable iff (!rstN)
		(opValid && op.kind == accWrite && op.sel == regNone) |=> $stable(latches));

endmodule

// File: source/neoIoRespQueue.sv
module neoIoRespQueue
	import neoIoPkg::*;
(
	input logic clk24M,
	input logic rstN,
	input logic pushValid,
	input ioRespT pushResp,
	input logic respTake,
	output logic respValid,
	output ioRespT resp,
	output logic creditReturn
);

	ioRespT mem [RespDepth];
	logic [RespPtrW-1:0] wrPtr;
	logic [RespPtrW-1:0] rdPtr;
	// One extra bit to tell full from empty
	logic [RespPtrW:0] count;
	logic pop;

	assign respValid = (count != '0);
	assign resp = mem[rdPtr];
	assign pop = respValid && respTake;

	// Response storage
	always_ff @(posedge clk24M) begin
		if (pushValid) begin
			mem[wrPtr] <= pushResp;
		end
	end

	// Pointers, occupancy and credit pulse
	always_ff @(posedge clk24M) begin
		if (!rstN) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
			creditReturn <= 1'b0;
		end else begin
			if (pushValid) begin
				wrPtr <= (wrPtr == RespPtrW'(RespDepth - 1)) ? '0 : wrPtr + RespPtrW'(1);
			end
			if (pop) begin
				rdPtr <= (rdPtr == RespPtrW'(RespDepth - 1)) ? '0 : rdPtr + RespPtrW'(1);
			end
			case ({pushValid, pop})
				2'b10: count <= count + (RespPtrW + 1)'(1);
				2'b01: count <= count - (RespPtrW + 1)'(1);
				default: count <= count;
			endcase
			// Credit goes back the cycle after the pop
			creditReturn <= pop;
		end
	end

	// Credit scheme must keep the queue from overflowing
	noOverflow: assert property (@(posedge clk24M) disable iff (!rstN)
		(count == (RespPtrW + 1)'(RespDepth)) |-> !pushValid);

endmodule

// File: source/neoIoTop.sv
module neoIoTop
	import neoIoPkg::*;
(
	input logic clk24M,
	input logic rstN,
	input logic reqValid,
	input ioReqT req,
	input logic [9:0] p1In,
	input logic [9:0] p2In,
	input logic testBtn,
	input logic [7:0] dipSw,
	output logic respValid,
	output ioRespT resp,
	input logic respTake,
	output logic creditReturn,
	output ioLatchT latches
);

	// Decode to register stage
	logic opValid;
	ioOpT op;
	// Register stage to response queue
	logic pushValid;
	ioRespT pushResp;

	neoIoDecode uDecode (
		.clk24M(clk24M),
		.rstN(rstN),
		.reqValid(reqValid),
		.req(req),
		.opValid(opValid),
		.op(op)
	);

	neoIoRegs uRegs (
		.clk24M(clk24M),
		.rstN(rstN),
		.opValid(opValid),
		.op(op),
		.p1In(p1In),
		.p2In(p2In),
		.testBtn(testBtn),
		.dipSw(dipSw),
		.pushValid(pushValid),
		.pushResp(pushResp),
		.latches(latches)
	);

	neoIoRespQueue uRespQueue (
		.clk24M(clk24M),
		.rstN(rstN),
		.pushValid(pushValid),
		.pushResp(pushResp),
		.respTake(respTake),
		.respValid(respValid),
		.resp(resp),
		.creditReturn(creditReturn)
	);

endmodule

// File: dv/neoIoTb.sv
module neoIoTb
	import neoIoPkg::*;
();

	localparam int NumEntries = 29;
	// Rough budget of 8 cycles per table entry plus slack for reset and the queue phases
	localparam int TimeoutCycles = NumEntries * 8 + 50;

	// One row of the stimulus table
	typedef struct packed {
		accessKindT kind;
		logic [23:0] addr;
		logic [7:0] data;
		regSelT sel;
		logic [7:0] expByte;
	} entryT;

	logic clk24M;
	logic rstN;
	logic reqValid;
	ioReqT req;
	logic [9:0] p1In;
	logic [9:0] p2In;
	logic testBtn;
	logic [7:0] dipSw;
	logic respValid;
	ioRespT resp;
	logic respTake;
	logic creditReturn;
	ioLatchT latches;

	entryT tbl [NumEntries];
	// Reference copy of the latches and of the staged LED byte
	ioLatchT modelLat;
	logic [7:0] modelLed;
	logic [31:0] lfsr;
	int credits;
	int cycleCount;
	logic [7:0] expQ [$];

	neoIoTop uut (
		.clk24M(clk24M),
		.rstN(rstN),
		.reqValid(reqValid),
		.req(req),
		.p1In(p1In),
		.p2In(p2In),
		.testBtn(testBtn),
		.dipSw(dipSw),
		.respValid(respValid),
		.resp(resp),
		.respTake(respTake),
		.creditReturn(creditReturn),
		.latches(latches)
	);

	initial begin
		clk24M = 1'b0;
		forever #50 clk24M = ~clk24M;
	end

	// Watchdog on the whole run
	initial begin
		cycleCount = 0;
		forever begin
			@(posedge clk24M);
			cycleCount++;
			if (cycleCount > TimeoutCycles) begin
				failRun("Timeout: the run did not finish within the cycle limit");
			end
		end
	end

	task automatic failRun(input string msg);
		$display("%s", msg);
		$display("Result: FAILED");
		$fatal(1, "Simulation stopped on the first error");
	endtask

	task automatic checkEq(input logic [63:0] got, input logic [63:0] exp, input string what);
		if (got !== exp) begin
			failRun($sformatf("[FAIL] %0t: %s: got %0h, expected %0h", $time, what, got, exp));
		end
	endtask

	// Fibonacci LFSR, taps 32 22 2 1, one step per bit taken
	function automatic logic [31:0] randBits(input int n);
		logic fb;
		logic [31:0] val;
		val = '0;
		for (int k = 0; k < n; k++) begin
			fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			val = {val[30:0], fb};
		end
		return val;
	endfunction

	function automatic entryT mk(input accessKindT kind, input logic [23:0] addr,
		input logic [7:0] data, input regSelT sel, input logic [7:0] expByte);
		entryT e;
		e.kind = kind;
		e.addr = addr;
		e.data = data;
		e.sel = sel;
		e.expByte = expByte;
		return e;
	endfunction

	// Expected read byte from the current port values
	function automatic logic [7:0] readModel(input regSelT sel);
		case (sel)
			regP1Cnt: return p1In[7:0];
			regP2Cnt: return p2In[7:0];
			regDipSw: return dipSw;
			regStatusA: return 8'hF8 | {7'd0, testBtn};
			regStatusB: return 8'hF0 | {4'd0, p2In[9:8], p1In[9:8]};
			default: return 8'hFF;
		endcase
	endfunction

	// Apply one write to the reference latches
	task automatic updateLatchModel(input entryT e);
		case (e.sel)
			regPOutput: begin
				modelLat.p1Out = e.data[2:0];
				modelLat.p2Out = e.data[5:3];
			end
			regCrdBank: modelLat.crdBank = e.data[2:0];
			regSlot: modelLat.slot = e.data[2:0];
			regLedData: modelLed = e.data;
			regLedLatch: begin
				if (e.data[3]) modelLat.led1 = modelLed;
				if (e.data[4]) modelLat.led2 = modelLed;
			end
			regCounter: begin
				// A4 is the value, A2:A1 the output
				case (e.addr[2:1])
					2'd0: modelLat.counter1 = e.addr[4];
					2'd1: modelLat.counter2 = e.addr[4];
					2'd2: modelLat.lockout1 = e.addr[4];
					default: modelLat.lockout2 = e.addr[4];
				endcase
			end
			regSysLatch: modelLat.sysLatch[e.addr[3:1]] = e.addr[4];
			default: begin
				// Dropped write
			end
		endcase
	endtask

	// Advance to 10 units past the next rising edge, collect returned credits
	task automatic stepCycle();
		@(posedge clk24M);
		#10;
		if (creditReturn) credits++;
	endtask

	// One request, spends a credit, waits if none is left
	task automatic issueReq(input accessKindT kind, input logic [23:0] addr, input logic [7:0] data);
		while (credits == 0) stepCycle();
		req.kind = kind;
		req.addr = addr;
		req.data = data;
		reqValid = 1'b1;
		credits--;
		stepCycle();
		reqValid = 1'b0;
	endtask

	// Wait for the response with random stalls on respTake, check it as it is popped
	task automatic takeResp(input logic [7:0] expData, input logic expWrite, input string what);
		logic take;
		logic done;
		done = 1'b0;
		while (!done) begin
			take = 1'b0;
			if (respValid) take = |randBits(2);
			respTake = take;
			if (take) begin
				checkEq(64'(resp.data), 64'(expData), {what, " data"});
				checkEq(64'(resp.wasWrite), 64'(expWrite), {what, " wasWrite"});
				done = 1'b1;
			end
			stepCycle();
		end
		respTake = 1'b0;
	endtask

	initial begin
		entryT e;
		logic [7:0] expByte;
		logic [23:0] a;
		regSelT s;
		int issued;
		int lat;
		lfsr = 32'h8268205b;
		rstN = 1'b0;
		reqValid = 1'b0;
		req = '0;
		p1In = '0;
		p2In = '0;
		testBtn = 1'b0;
		dipSw = '0;
		respTake = 1'b0;
		credits = RespDepth;
		modelLat = '0;
		modelLed = '0;
		expQ.delete();

		// Reads, then the unmapped and wrong-direction cases
		tbl[0] = mk(accRead, 24'h300000, 8'h00, regP1Cnt, 8'h00);
		tbl[1] = mk(accRead, 24'h340000, 8'h00, regP2Cnt, 8'h00);
		tbl[2] = mk(accRead, 24'h300001, 8'h00, regDipSw, 8'h00);
		tbl[3] = mk(accRead, 24'h320001, 8'h00, regStatusA, 8'h00);
		tbl[4] = mk(accRead, 24'h380000, 8'h00, regStatusB, 8'h00);
		tbl[5] = mk(accRead, 24'h300081, 8'h00, regNone, 8'hFF);
		tbl[6] = mk(accRead, 24'h360000, 8'h00, regNone, 8'hFF);
		tbl[7] = mk(accRead, 24'h380001, 8'h00, regNone, 8'hFF);
		tbl[8] = mk(accRead, 24'h3A0001, 8'h00, regNone, 8'hFF);
		// Output latches and LEDs
		tbl[9] = mk(accWrite, 24'h380001, 8'h2D, regPOutput, 8'h00);
		tbl[10] = mk(accWrite, 24'h380011, 8'h06, regCrdBank, 8'h00);
		tbl[11] = mk(accWrite, 24'h380021, 8'h03, regSlot, 8'h00);
		tbl[12] = mk(accWrite, 24'h380041, 8'hA5, regLedData, 8'h00);
		tbl[13] = mk(accWrite, 24'h380031, 8'h08, regLedLatch, 8'h00);
		tbl[14] = mk(accWrite, 24'h380041, 8'h3C, regLedData, 8'h00);
		tbl[15] = mk(accWrite, 24'h380031, 8'h10, regLedLatch, 8'h00);
		// Coin counters and lockouts, set all then clear counter1
		tbl[16] = mk(accWrite, 24'h380071, 8'h00, regCounter, 8'h00);
		tbl[17] = mk(accWrite, 24'h380073, 8'h00, regCounter, 8'h00);
		tbl[18] = mk(accWrite, 24'h380075, 8'h00, regCounter, 8'h00);
		tbl[19] = mk(accWrite, 24'h380077, 8'h00, regCounter, 8'h00);
		tbl[20] = mk(accWrite, 24'h380061, 8'h00, regCounter, 8'h00);
		// RTC control is ignored
		tbl[21] = mk(accWrite, 24'h380051, 8'hFF, regNone, 8'h00);
		// System latch bits 0, 7, 7 cleared, 2
		tbl[22] = mk(accWrite, 24'h3A0011, 8'h00, regSysLatch, 8'h00);
		tbl[23] = mk(accWrite, 24'h3A001F, 8'h00, regSysLatch, 8'h00);
		tbl[24] = mk(accWrite, 24'h3A000F, 8'h00, regSysLatch, 8'h00);
		tbl[25] = mk(accWrite, 24'h3A0015, 8'h00, regSysLatch, 8'h00);
		// Writes to read-only ports
		tbl[26] = mk(accWrite, 24'h300000, 8'hFF, regNone, 8'h00);
		tbl[27] = mk(accWrite, 24'h320001, 8'hFF, regNone, 8'h00);
		tbl[28] = mk(accRead, 24'h300000, 8'h00, regP1Cnt, 8'h00);

		repeat (5) @(posedge clk24M);
		#10;
		rstN = 1'b1;
		stepCycle();
		checkEq(64'(respValid), 64'd0, "respValid after reset");
		checkEq(64'(creditReturn), 64'd0, "creditReturn after reset");
		checkEq(64'(latches), 64'd0, "latches after reset");

		// Table loop, one access in flight at a time
		for (int i = 0; i < NumEntries; i++) begin
			e = tbl[i];
			p1In = 10'(randBits(10));
			p2In = 10'(randBits(10));
			dipSw = 8'(randBits(8));
			testBtn = 1'(randBits(1));
			expByte = e.expByte;
			if (e.kind == accRead && e.sel != regNone) begin
				expByte = readModel(e.sel);
			end else if (e.kind == accWrite) begin
				updateLatchModel(e);
			end
			issueReq(e.kind, e.addr, e.data);
			takeResp(expByte, 1'(e.kind == accWrite), $sformatf("entry %0d", i));
			checkEq(64'(latches), 64'(modelLat), $sformatf("latches after entry %0d", i));
		end
		checkEq(64'(credits), 64'(RespDepth), "credits after table");

		// Fill the queue with respTake held low, credits run out at RespDepth
		issued = 0;
		while (credits > 0) begin
			case (issued % 4)
				0: begin
					a = 24'h300001;
					s = regDipSw;
				end
				1: begin
					a = 24'h300000;
					s = regP1Cnt;
				end
				2: begin
					a = 24'h320001;
					s = regStatusA;
				end
				default: begin
					a = 24'h380000;
					s = regStatusB;
				end
			endcase
			expQ.push_back(readModel(s));
			issueReq(accRead, a, 8'h00);
			issued++;
		end
		checkEq(64'(issued), 64'(RespDepth), "requests issued on full credit");
		repeat (3) stepCycle();
		checkEq(64'(respValid), 64'd1, "respValid with full queue");
		checkEq(64'(credits), 64'd0, "credits while queue full");

		// Drain one at a time, each pop gives one credit pulse
		while (expQ.size() > 0) begin
			respTake = 1'b1;
			checkEq(64'(resp.data), 64'(expQ.pop_front()), "queued response order");
			stepCycle();
			respTake = 1'b0;
			checkEq(64'(creditReturn), 64'd1, "creditReturn after pop");
			stepCycle();
			checkEq(64'(creditReturn), 64'd0, "creditReturn is one pulse");
		end
		checkEq(64'(respValid), 64'd0, "queue empty after drain");
		checkEq(64'(credits), 64'(RespDepth), "credits after drain");

		// Latency on an idle queue
		respTake = 1'b1;
		expByte = readModel(regP1Cnt);
		req.kind = accRead;
		req.addr = 24'h300000;
		req.data = 8'h00;
		reqValid = 1'b1;
		credits--;
		stepCycle();
		reqValid = 1'b0;
		lat = 1;
		while (!respValid) begin
			stepCycle();
			lat++;
		end
		checkEq(64'(lat), 64'd3, "latency to respValid");
		checkEq(64'(resp.data), 64'(expByte), "latency read data");
		stepCycle();
		respTake = 1'b0;
		stepCycle();
		checkEq(64'(credits), 64'(RespDepth), "credits at end");

		$display("Result: PASSED");
		$finish;
	end

endmodule

// File: list.f
source/neoIoPkg.sv
source/neoIoDecode.sv
source/neoIoRegs.sv
source/neoIoRespQueue.sv
source/neoIoTop.sv
dv/neoIoTb.sv

// File: Makefile
# Verilator build of the I/O zone model and its testbench

TOP ?= neoIoTb
OBJDIR ?= obj_dir
FLAGS ?= --binary --timing --assert -j 0
FILELIST := list.f

.PHONY: all compile run clean

all: run

compile:
	verilator $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

# The simulator exits non-zero on $fatal, so make fails with it
run: compile
	./$(OBJDIR)/V$(TOP)

clean:
	rm -rf $(OBJDIR)
